// File: dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ==========================================================
// Cache geometry
// ==========================================================
`define DC_ADDR_BITS     32
`define DC_DATA_BITS     32
`define DC_INDEX_BITS    6
`define DC_LINES         64
`define DC_TAG_BITS      22
`define DC_LINE_BITS     128
`define DC_BYTE_EN_BITS  16
// Words per line, one beat each on a fill
`define DC_BEATS         4

// ==========================================================
// Uncacheable regions, matched on address bits 31:16
// ==========================================================
`define DC_UNCACHED_HI0  16'h1000
`define DC_UNCACHED_HI1  16'h4000

`endif

// File: dcache_ctrl.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           core_req,
    input  logic                           core_write,
    input  dcache_pkg::core_addr_u         core_addr,
    input  dcache_pkg::core_addr_u         req_addr,
    input  logic                           req_write,
    input  logic                           req_cacheable,
    input  logic [`DC_INDEX_BITS-1:0]      index,
    input  logic [`DC_TAG_BITS-1:0]        tag_rdata,
    input  logic                           beat_done,
    output dcache_pkg::cache_state_e       state,
    output logic [$clog2(`DC_BEATS)-1:0]   beat_cnt,
    output logic                           tag_we,
    output logic                           data_we_line,
    output logic                           idle,
    output logic                           core_wait
);

    dcache_pkg::cache_state_e next_state;
    logic [`DC_LINES-1:0]     valid;
    logic                     live_cacheable;
    logic                     hit;
    logic                     last_beat;

    assign live_cacheable = (core_addr.region.hi != `DC_UNCACHED_HI0) &&
                            (core_addr.region.hi != `DC_UNCACHED_HI1);

    // Tag read was launched in IDLE, so it is ready in CHECK
    // CHECK is entered only for a valid cacheable line
    assign hit = (tag_rdata == req_addr.cache.tag);

    // All ones on the beat counter marks the final beat
    assign last_beat = (state == dcache_pkg::READ_FILL) && beat_done && (&beat_cnt);

    // ==========================================================
    // State machine
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (core_req) begin
                    if (!live_cacheable) begin
                        next_state = dcache_pkg::UNCACHED;
                    end else if (!valid[index]) begin
                        // No valid tag to compare against so CHECK is skipped
                        next_state = core_write ? dcache_pkg::WRITE_MISS
                                                : dcache_pkg::READ_FILL;
                    end else begin
                        next_state = dcache_pkg::CHECK;
                    end
                end
            end
            dcache_pkg::CHECK: begin
                if (req_write) begin
                    next_state = hit ? dcache_pkg::WRITE_HIT : dcache_pkg::WRITE_MISS;
                end else begin
                    next_state = hit ? dcache_pkg::DONE : dcache_pkg::READ_FILL;
                end
            end
            dcache_pkg::WRITE_HIT,
            dcache_pkg::WRITE_MISS,
            dcache_pkg::UNCACHED: begin
                if (beat_done) begin
                    next_state = dcache_pkg::DONE;
                end
            end
            dcache_pkg::READ_FILL: begin
                if (last_beat) begin
                    next_state = dcache_pkg::DONE;
                end
            end
            dcache_pkg::DONE: next_state = dcache_pkg::IDLE;
            default:          next_state = dcache_pkg::IDLE;
        endcase
    end

    // ==========================================================
    // Fill beat counter and valid bits
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (state != dcache_pkg::READ_FILL) begin
            beat_cnt <= '0;
        end else if (beat_done) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (tag_we) begin
            valid[index] <= 1'b1;
        end
    end

    // Array strobes
    assign tag_we       = last_beat;
    assign data_we_line = last_beat || ((state == dcache_pkg::WRITE_HIT) && beat_done);

    // Core handshake
    assign idle      = (state == dcache_pkg::IDLE);
    assign core_wait = idle ? core_req : (state != dcache_pkg::DONE);

endmodule

`default_nettype wire

// File: dcache_data_array.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_data_array (
    input  logic                          clk,
    input  logic [`DC_INDEX_BITS-1:0]     index,
    input  logic [`DC_BYTE_EN_BITS-1:0]   byte_we,
    input  logic [`DC_LINE_BITS-1:0]      line_wdata,
    output logic [`DC_LINE_BITS-1:0]      data_rdata
);

    logic [`DC_LINE_BITS-1:0] lines [`DC_LINES];

    // ==========================================================
    // Line storage with byte lanes
    // ==========================================================
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_BYTE_EN_BITS; b++) begin
            if (byte_we[b]) begin
                lines[index][b*8 +: 8] <= line_wdata[b*8 +: 8];
            end
        end
        // Whole line out, the word is picked downstream
        data_rdata <= lines[index];
    end

endmodule

`default_nettype wire

// File: dcache_line_buffer.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_line_buffer (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::cache_state_e       state,
    input  logic [$clog2(`DC_BEATS)-1:0]   beat_cnt,
    input  logic                           beat_done,
    input  logic [`DC_DATA_BITS-1:0]       mem_rdata,
    input  dcache_pkg::core_addr_u         req_addr,
    input  dcache_pkg::access_type_e       req_type,
    input  logic [`DC_DATA_BITS-1:0]       req_wdata,
    input  logic                           data_we_line,
    output logic [`DC_LINE_BITS-1:0]       line_wdata,
    output logic [`DC_BYTE_EN_BITS-1:0]    byte_we,
    output logic [`DC_DATA_BITS-1:0]       fill_word
);

    // Only the first three beats are buffered, the last one is still on mem_rdata
    logic [`DC_LINE_BITS-`DC_DATA_BITS-1:0] fill_buf;
    logic [`DC_LINE_BITS-1:0]               fill_line;
    logic [3:0]                             word_be;
    logic [`DC_BYTE_EN_BITS-1:0]            store_be;

    always_ff @(posedge clk) begin
        if ((state == dcache_pkg::READ_FILL) && beat_done && !(&beat_cnt)) begin
            fill_buf[beat_cnt * `DC_DATA_BITS +: `DC_DATA_BITS] <= mem_rdata;
        end
    end

    assign fill_line = {mem_rdata, fill_buf};
    assign fill_word = fill_line[req_addr.cache.word_off * `DC_DATA_BITS +: `DC_DATA_BITS];

    // ==========================================================
    // Store byte enables
    // ==========================================================
    // Store data arrives lane aligned from the core
    always_comb begin
        case (req_type)
            dcache_pkg::BYTE: word_be = 4'b0001 << req_addr.cache.byte_off;
            dcache_pkg::HALF: word_be = 4'b0011 << {req_addr.cache.byte_off[1], 1'b0};
            default:          word_be = 4'b1111;
        endcase
        store_be = '0;
        store_be[{req_addr.cache.word_off, 2'b00} +: 4] = word_be;
    end

    // Array write lands one cycle after the controller strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_we <= '0;
        end else if (!data_we_line) begin
            byte_we <= '0;
        end else if (state == dcache_pkg::READ_FILL) begin
            byte_we <= '1;
        end else begin
            byte_we <= store_be;
        end
    end

    always_ff @(posedge clk) begin
        if (data_we_line) begin
            line_wdata <= (state == dcache_pkg::READ_FILL) ? fill_line
                                                           : {`DC_BEATS{req_wdata}};
        end
    end

endmodule

`default_nettype wire

// File: dcache_mem_port.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_mem_port (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::cache_state_e       state,
    input  logic [$clog2(`DC_BEATS)-1:0]   beat_cnt,
    input  logic                           beat_done,
    input  dcache_pkg::core_addr_u         req_addr,
    input  logic                           req_write,
    input  logic [`DC_DATA_BITS-1:0]       req_wdata,
    input  dcache_pkg::access_type_e       req_type,
    input  logic [`DC_LINE_BITS-1:0]       data_rdata,
    input  logic [`DC_DATA_BITS-1:0]       fill_word,
    input  logic [`DC_DATA_BITS-1:0]       mem_rdata,
    output logic                           mem_req,
    output logic [`DC_ADDR_BITS-1:0]       mem_addr,
    output logic                           mem_write,
    output logic [`DC_DATA_BITS-1:0]       mem_wdata,
    output dcache_pkg::access_type_e       mem_type,
    output logic                           mem_single,
    output logic [`DC_DATA_BITS-1:0]       core_rdata
);

    logic mem_state;
    logic req_sent;
    logic fill;

    assign fill      = (state == dcache_pkg::READ_FILL);
    assign mem_state = fill || (state == dcache_pkg::WRITE_HIT) ||
                       (state == dcache_pkg::WRITE_MISS) || (state == dcache_pkg::UNCACHED);

    // ==========================================================
    // Memory request, one strobe per transaction
    // ==========================================================
    // Memory states never follow each other, DONE sits between them
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_sent <= 1'b0;
        end else begin
            req_sent <= mem_state;
        end
    end

    assign mem_req    = mem_state && !req_sent;
    assign mem_addr   = fill ? {req_addr.cache.tag, req_addr.cache.index, 4'b0000} : req_addr;
    assign mem_write  = req_write && !fill;
    assign mem_wdata  = req_wdata;
    assign mem_type   = fill ? dcache_pkg::WORD : req_type;
    assign mem_single = !fill;

    // Read result for the core, valid in DONE
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            core_rdata <= '0;
        end else if (state == dcache_pkg::CHECK) begin
            core_rdata <= data_rdata[req_addr.cache.word_off * `DC_DATA_BITS +: `DC_DATA_BITS];
        end else if (fill && beat_done && (&beat_cnt)) begin
            core_rdata <= fill_word;
        end else if ((state == dcache_pkg::UNCACHED) && beat_done && !req_write) begin
            core_rdata <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none
`include "dcache_consts.svh"

package dcache_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        CHECK      = 3'd1,
        WRITE_HIT  = 3'd2,
        WRITE_MISS = 3'd3,
        READ_FILL  = 3'd4,
        UNCACHED   = 3'd5,
        DONE       = 3'd6
    } cache_state_e;

    // Core access size, same code on the memory side
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } access_type_e;

    // One address word, seen either by the cache or by the region decoder
    typedef union packed {
        struct packed {
            logic [`DC_TAG_BITS-1:0]   tag;
            logic [`DC_INDEX_BITS-1:0] index;
            logic [1:0]                word_off;
            logic [1:0]                byte_off;
        } cache;
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } region;
    } core_addr_u;

endpackage

`default_nettype wire

// File: dcache_req_capture.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_req_capture (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::core_addr_u         core_addr,
    input  logic                           core_write,
    input  logic [`DC_DATA_BITS-1:0]       core_wdata,
    input  dcache_pkg::access_type_e       core_type,
    input  logic                           idle,
    output dcache_pkg::core_addr_u         req_addr,
    output logic                           req_write,
    output logic [`DC_DATA_BITS-1:0]       req_wdata,
    output dcache_pkg::access_type_e       req_type,
    output logic                           req_cacheable,
    output logic [`DC_INDEX_BITS-1:0]      index
);

    logic live_cacheable;

    // Region decode on the upper halfword of the live address
    assign live_cacheable = (core_addr.region.hi != `DC_UNCACHED_HI0) &&
                            (core_addr.region.hi != `DC_UNCACHED_HI1);

    // ==========================================================
    // Request sampling, open only while the controller is idle
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_write     <= 1'b0;
            req_cacheable <= 1'b0;
        end else if (idle) begin
            req_write     <= core_write;
            req_cacheable <= live_cacheable;
        end
    end

    always_ff @(posedge clk) begin
        if (idle) begin
            req_addr  <= core_addr;
            req_wdata <= core_wdata;
            req_type  <= core_type;
        end
    end

    // Arrays read with the live index during acceptance,
    // then stay on the held line until the access ends
    assign index = idle ? core_addr.cache.index : req_addr.cache.index;

endmodule

`default_nettype wire

// File: dcache_tag_array.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_tag_array (
    input  logic                        clk,
    input  logic [`DC_INDEX_BITS-1:0]   index,
    input  logic                        tag_we,
    input  logic [`DC_TAG_BITS-1:0]     tag_wdata,
    output logic [`DC_TAG_BITS-1:0]     tag_rdata
);

    logic [`DC_TAG_BITS-1:0] tags [`DC_LINES];

    // Single port, read every cycle, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[index] <= tag_wdata;
        end
        tag_rdata <= tags[index];
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`default_nettype none
`include "dcache_consts.svh"

module dcache_top (
    input  logic                         clk,
    input  logic                         rst,
    // Core side
    input  logic [`DC_ADDR_BITS-1:0]     core_addr,
    input  logic                         core_req,
    input  logic                         core_write,
    input  logic [`DC_DATA_BITS-1:0]     core_wdata,
    input  dcache_pkg::access_type_e     core_type,
    output logic [`DC_DATA_BITS-1:0]     core_rdata,
    output logic                         core_wait,
    // Memory side
    output logic                         mem_req,
    output logic [`DC_ADDR_BITS-1:0]     mem_addr,
    output logic                         mem_write,
    output logic [`DC_DATA_BITS-1:0]     mem_wdata,
    output dcache_pkg::access_type_e     mem_type,
    output logic                         mem_single,
    input  logic [`DC_DATA_BITS-1:0]     mem_rdata,
    input  logic                         mem_wait
);

    dcache_pkg::core_addr_u           req_addr;
    dcache_pkg::access_type_e         req_type;
    dcache_pkg::cache_state_e         state;
    logic                             req_write;
    logic                             req_cacheable;
    logic [`DC_DATA_BITS-1:0]         req_wdata;
    logic [`DC_INDEX_BITS-1:0]        index;
    logic [`DC_TAG_BITS-1:0]          tag_rdata;
    logic [`DC_LINE_BITS-1:0]         data_rdata;
    logic [`DC_LINE_BITS-1:0]         line_wdata;
    logic [`DC_BYTE_EN_BITS-1:0]      byte_we;
    logic [`DC_DATA_BITS-1:0]         fill_word;
    logic [$clog2(`DC_BEATS)-1:0]     beat_cnt;
    logic                             tag_we;
    logic                             data_we_line;
    logic                             idle;

    dcache_req_capture u_capture (
        .clk, .rst, .core_addr, .core_write, .core_wdata, .core_type, .idle,
        .req_addr, .req_write, .req_wdata, .req_type, .req_cacheable, .index
    );

    dcache_ctrl u_ctrl (
        .clk, .rst, .core_req, .core_write, .core_addr, .req_addr, .req_write,
        .req_cacheable, .index, .tag_rdata, .beat_done(!mem_wait),
        .state, .beat_cnt, .tag_we, .data_we_line, .idle, .core_wait
    );

    dcache_tag_array u_tag_array (
        .clk, .index, .tag_we, .tag_wdata(req_addr.cache.tag), .tag_rdata
    );

    dcache_data_array u_data_array (
        .clk, .index, .byte_we, .line_wdata, .data_rdata
    );

    dcache_line_buffer u_line_buffer (
        .clk, .rst, .state, .beat_cnt, .beat_done(!mem_wait), .mem_rdata, .req_addr,
        .req_type, .req_wdata, .data_we_line, .line_wdata, .byte_we, .fill_word
    );

    dcache_mem_port u_mem_port (
        .clk, .rst, .state, .beat_cnt, .beat_done(!mem_wait), .req_addr, .req_write,
        .req_wdata, .req_type, .data_rdata, .fill_word, .mem_rdata, .mem_req, .mem_addr,
        .mem_write, .mem_wdata, .mem_type, .mem_single, .core_rdata
    );

endmodule

`default_nettype wire

// File: list.f
+incdir+.
dcache_pkg.sv
dcache_req_capture.sv
dcache_ctrl.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_line_buffer.sv
dcache_mem_port.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_dcache \
    -f list.f -Mdir obj_dir -o sim_dcache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tb_dcache.sv
`default_nettype none
`include "dcache_consts.svh"

module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string                    name;
        logic                     wr;
        logic [31:0]              addr;
        dcache_pkg::access_type_e typ;
        logic [31:0]              wdata;
        logic [31:0]              exp_data;
        int                       exp_fill;
        int                       exp_read;
        int                       exp_write;
        logic                     exp_hit;
    } test_t;

    logic                     clk = 1'b0;
    logic                     rst;
    logic [31:0]              core_addr;
    logic                     core_req;
    logic                     core_write;
    logic [31:0]              core_wdata;
    dcache_pkg::access_type_e core_type;
    logic [31:0]              core_rdata;
    logic                     core_wait;
    logic                     mem_req;
    logic [31:0]              mem_addr;
    logic                     mem_write;
    logic [31:0]              mem_wdata;
    dcache_pkg::access_type_e mem_type;
    logic                     mem_single;
    logic [31:0]              mem_rdata;
    logic                     mem_wait;

    test_t       tests [$];
    logic [31:0] mirror [bit [31:0]];
    int          errs;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic        timed_out = 1'b0;

    always #2 clk = ~clk;

    dcache_top UUT (
        .clk, .rst, .core_addr, .core_req, .core_write, .core_wdata, .core_type,
        .core_rdata, .core_wait, .mem_req, .mem_addr, .mem_write, .mem_wdata,
        .mem_type, .mem_single, .mem_rdata, .mem_wait
    );

    tb_mem_model u_mem (
        .clk, .mem_req, .mem_addr, .mem_write, .mem_wdata, .mem_type, .mem_single,
        .mem_rdata, .mem_wait
    );

    // ==========================================================
    // Expected memory and cache contents
    // ==========================================================
    function automatic logic [31:0] mirror_word(input logic [31:0] a);
        if (mirror.exists({a[31:2], 2'b00})) begin
            return mirror[{a[31:2], 2'b00}];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a0000;
    endfunction

    function automatic logic [31:0] store_mask(input dcache_pkg::access_type_e t,
                                               input logic [1:0] off);
        case (t)
            dcache_pkg::BYTE: store_mask = 32'h0000_00ff << (8 * off);
            dcache_pkg::HALF: store_mask = off[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:          store_mask = 32'hffff_ffff;
        endcase
    endfunction

    task automatic add_test(input string name, input logic wr, input logic [31:0] addr,
                            input dcache_pkg::access_type_e typ, input logic [31:0] wdata);
        test_t t;
        t.name  = name;
        t.wr    = wr;
        t.addr  = addr;
        t.typ   = typ;
        t.wdata = wdata;
        tests.push_back(t);
    endtask

    task automatic build_table();
        add_test("read_miss_a",      1'b0, 32'h0000_0104, dcache_pkg::WORD, 32'h0);
        add_test("read_hit_a_w0",    1'b0, 32'h0000_0100, dcache_pkg::WORD, 32'h0);
        add_test("read_hit_a_w3",    1'b0, 32'h0000_010c, dcache_pkg::WORD, 32'h0);
        add_test("write_hit_byte",   1'b1, 32'h0000_0105, dcache_pkg::BYTE, 32'hdead_beef);
        add_test("read_after_byte",  1'b0, 32'h0000_0104, dcache_pkg::WORD, 32'h0);
        add_test("write_hit_half",   1'b1, 32'h0000_010a, dcache_pkg::HALF, 32'h1234_5678);
        add_test("read_after_half",  1'b0, 32'h0000_0108, dcache_pkg::WORD, 32'h0);
        add_test("write_hit_word",   1'b1, 32'h0000_010c, dcache_pkg::WORD, 32'hcafe_f00d);
        add_test("read_after_word",  1'b0, 32'h0000_010c, dcache_pkg::WORD, 32'h0);
        add_test("write_miss_cold",  1'b1, 32'h0000_0200, dcache_pkg::WORD, 32'h0bad_cafe);
        add_test("read_after_miss",  1'b0, 32'h0000_0200, dcache_pkg::WORD, 32'h0);
        add_test("uc_read_1000",     1'b0, 32'h1000_0040, dcache_pkg::WORD, 32'h0);
        add_test("uc_read_1000_rep", 1'b0, 32'h1000_0040, dcache_pkg::WORD, 32'h0);
        add_test("uc_write_1000",    1'b1, 32'h1000_0040, dcache_pkg::HALF, 32'h7777_8888);
        add_test("uc_read_1000_new", 1'b0, 32'h1000_0040, dcache_pkg::WORD, 32'h0);
        add_test("uc_write_4000",    1'b1, 32'h4000_0018, dcache_pkg::WORD, 32'h4444_0000);
        add_test("uc_read_4000",     1'b0, 32'h4000_0018, dcache_pkg::WORD, 32'h0);
        add_test("replace_b",        1'b0, 32'h0001_0104, dcache_pkg::HALF, 32'h0);
        add_test("replace_a",        1'b0, 32'h0000_0104, dcache_pkg::WORD, 32'h0);
        add_test("replace_b_again",  1'b0, 32'h0001_0104, dcache_pkg::WORD, 32'h0);
        add_test("write_miss_tag",   1'b1, 32'h0000_0108, dcache_pkg::WORD, 32'h5555_aaaa);
        add_test("read_after_tag",   1'b0, 32'h0000_0108, dcache_pkg::WORD, 32'h0);
    endtask

    // Walks the table in order and tracks memory and the valid bit and tag of each line
    task automatic predict_results();
        logic [`DC_LINES-1:0]    valid_m;
        logic [`DC_TAG_BITS-1:0] tag_m [`DC_LINES];
        logic [5:0]              idx;
        logic                    cacheable;
        logic                    hit;
        logic [31:0]             a;
        logic [31:0]             m;
        test_t                   t;
        valid_m = '0;
        for (int i = 0; i < tests.size(); i++) begin
            t         = tests[i];
            a         = t.addr;
            idx       = a[9:4];
            cacheable = (a[31:16] != `DC_UNCACHED_HI0) && (a[31:16] != `DC_UNCACHED_HI1);
            hit       = cacheable && valid_m[idx] && (tag_m[idx] == a[31:10]);
            t.exp_fill  = 0;
            t.exp_read  = 0;
            t.exp_write = 0;
            t.exp_hit   = !t.wr && hit;
            if (t.wr) begin
                m = store_mask(t.typ, a[1:0]);
                mirror[{a[31:2], 2'b00}] = (mirror_word(a) & ~m) | (t.wdata & m);
                t.exp_write = 1;
            end else if (!cacheable) begin
                t.exp_read = 1;
            end else if (!hit) begin
                t.exp_fill   = 1;
                valid_m[idx] = 1'b1;
                tag_m[idx]   = a[31:10];
            end
            t.exp_data = mirror_word(a);
            tests[i]   = t;
        end
    endtask

    // ==========================================================
    // Checks and test sequencing
    // ==========================================================
    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("FAIL %s: %s expected %h, actual %h", name, what, exp, act);
            errs++;
        end
    endtask

    task automatic run_test(input test_t t);
        int   f0;
        int   r0;
        int   w0;
        int   lat;
        logic seen;
        errs = 0;
        f0   = u_mem.fill_cnt;
        r0   = u_mem.read_cnt;
        w0   = u_mem.write_cnt;
        @(posedge clk);
        #1;
        core_addr  = t.addr;
        core_write = t.wr;
        core_wdata = t.wdata;
        core_type  = t.typ;
        core_req   = 1'b1;
        lat  = 0;
        seen = 1'b0;
        // The first edge accepts the request and DONE shows as core_wait low
        while (!seen && lat < 200) begin
            @(posedge clk);
            #1;
            core_req = 1'b0;
            lat++;
            seen = !core_wait;
        end
        assert (seen) else begin
            $display("Test %s timed out, core_wait stayed high for 200 cycles", t.name);
            errs++;
            timed_out = 1'b1;
        end
        if (seen) begin
            if (!t.wr) begin
                check_value(t.name, "read data", t.exp_data, core_rdata);
            end
            check_value(t.name, "line fills", t.exp_fill, u_mem.fill_cnt - f0);
            check_value(t.name, "single reads", t.exp_read, u_mem.read_cnt - r0);
            check_value(t.name, "writes", t.exp_write, u_mem.write_cnt - w0);
            if (t.exp_hit) begin
                check_value(t.name, "hit latency", 2, lat);
            end
            if (t.exp_fill == 1) begin
                check_value(t.name, "fill address", {t.addr[31:4], 4'h0}, u_mem.last_addr);
                check_value(t.name, "fill type", {30'b0, dcache_pkg::WORD},
                            {30'b0, u_mem.last_type});
            end
            if (t.exp_read == 1) begin
                check_value(t.name, "single address", t.addr, u_mem.last_addr);
                check_value(t.name, "single flag", 1, {31'b0, u_mem.last_single});
            end
        end
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("Test %s %s", t.name, (errs == 0) ? "passed" : "failed");
    endtask

    initial begin
        rst        = 1'b1;
        core_addr  = '0;
        core_req   = 1'b0;
        core_write = 1'b0;
        core_wdata = '0;
        core_type  = dcache_pkg::WORD;
        build_table();
        predict_results();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < tests.size() && !timed_out; i++) begin
            run_test(tests[i]);
        end
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`default_nettype none
`include "dcache_consts.svh"

module tb_mem_model (
    input  logic                       clk,
    input  logic                       mem_req,
    input  logic [`DC_ADDR_BITS-1:0]   mem_addr,
    input  logic                       mem_write,
    input  logic [`DC_DATA_BITS-1:0]   mem_wdata,
    input  dcache_pkg::access_type_e   mem_type,
    input  logic                       mem_single,
    output logic [`DC_DATA_BITS-1:0]   mem_rdata,
    output logic                       mem_wait
);
    timeunit 1ns;
    timeprecision 100ps;

    // Sparse word store, keyed by word address
    logic [31:0]              words [bit [31:0]];
    integer                   seed;
    int                       fill_cnt;
    int                       read_cnt;
    int                       write_cnt;
    int                       nbeats;
    int                       waits;
    logic [31:0]              last_addr;
    logic                     last_single;
    dcache_pkg::access_type_e last_type;
    logic [31:0]              waddr;
    logic [31:0]              cur;
    logic [3:0]               lanes;

    // Untouched words hold their address mixed with a fixed pattern
    function automatic logic [31:0] stored_word(input logic [31:0] a);
        if (words.exists(a)) begin
            return words[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic logic [3:0] byte_lanes(input dcache_pkg::access_type_e t,
                                              input logic [1:0] off);
        case (t)
            dcache_pkg::BYTE: byte_lanes = 4'b0001 << off;
            dcache_pkg::HALF: byte_lanes = off[1] ? 4'b1100 : 4'b0011;
            default:          byte_lanes = 4'b1111;
        endcase
    endfunction

    initial begin
        seed      = 32'h4fe7;
        fill_cnt  = 0;
        read_cnt  = 0;
        write_cnt = 0;
        mem_wait  = 1'b1;
        mem_rdata = '0;
        forever begin
            // Strobe is steady over the whole first cycle of a transaction
            @(negedge clk);
            if (mem_req) begin
                waddr       = {mem_addr[31:2], 2'b00};
                last_addr   = mem_addr;
                last_single = mem_single;
                last_type   = mem_type;
                if (mem_write) begin
                    write_cnt++;
                end else if (mem_single) begin
                    read_cnt++;
                end else begin
                    fill_cnt++;
                end
                nbeats = (!mem_write && !mem_single) ? `DC_BEATS : 1;
                @(posedge clk);
                for (int b = 0; b < nbeats; b++) begin
                    waits = $unsigned($random(seed)) % 4;
                    repeat (waits) begin
                        #1;
                        mem_wait = 1'b1;
                        @(posedge clk);
                    end
                    #1;
                    mem_wait  = 1'b0;
                    mem_rdata = stored_word(waddr + 4 * b);
                    if (mem_write) begin
                        cur   = stored_word(waddr);
                        lanes = byte_lanes(mem_type, mem_addr[1:0]);
                        for (int l = 0; l < 4; l++) begin
                            if (lanes[l]) begin
                                cur[8*l +: 8] = mem_wdata[8*l +: 8];
                            end
                        end
                        words[waddr] = cur;
                    end
                    @(posedge clk);
                end
                #1;
                mem_wait = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
